/* rtl/isa_pkg.sv */
// ------------------------------------------------
// isa package
// data word, register index and ALU opcode types
// ------------------------------------------------
`default_nettype none

package isa_pkg;

    // data path width
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             data_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // ALU operations, shifts take the low 5 bits of operand b
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_SLL = 3'd6,
        OP_SRL = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/core_pkg.sv */
// ------------------------------------------------
// core package
// reorder buffer and pipeline types of the OoO core
// ------------------------------------------------
`default_nettype none

package core_pkg;

    // reorder buffer size, tags index its entries
    localparam int ROB_DEPTH = 8;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    // life of a ROB entry
    typedef enum logic [1:0] {
        ROB_FREE = 2'd0,
        ROB_WAIT = 2'd1,
        ROB_DONE = 2'd2
    } rob_state_e;

    // ALU latency from dispatch to common data bus
    localparam int ALU_STAGES = 2;

endpackage

`default_nettype wire

/* rtl/issue_unit.sv */
// ------------------------------------------------
// issue unit
// register file, register status table and operand
// lookup with renaming of the destination register
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ins_valid,
    input  isa_pkg::alu_op_e    ins_op,
    input  isa_pkg::reg_idx_t   ins_rd,
    input  isa_pkg::reg_idx_t   ins_rs1,
    input  isa_pkg::reg_idx_t   ins_rs2,
    input  logic                ins_use_imm,
    input  isa_pkg::data_t      ins_imm,
    input  logic                ins_stall,
    input  core_pkg::rob_tag_t  alloc_tag,
    input  logic                rob_rd_ready_a,
    input  logic                rob_rd_ready_b,
    input  isa_pkg::data_t      rob_rd_value_a,
    input  isa_pkg::data_t      rob_rd_value_b,
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    input  logic                commit_valid,
    input  core_pkg::rob_tag_t  commit_tag,
    input  isa_pkg::reg_idx_t   commit_rd,
    input  isa_pkg::data_t      commit_data,
    output logic                issue_en,
    output isa_pkg::alu_op_e    issue_op,
    output isa_pkg::reg_idx_t   issue_rd,
    output isa_pkg::data_t      vj,
    output isa_pkg::data_t      vk,
    output core_pkg::rob_tag_t  qj,
    output core_pkg::rob_tag_t  qk,
    output logic                rj,
    output logic                rk,
    output core_pkg::rob_tag_t  rob_rd_tag_a,
    output core_pkg::rob_tag_t  rob_rd_tag_b
);

    // architectural state and rename table
    isa_pkg::data_t                  rf_q   [isa_pkg::NUM_REGS];
    core_pkg::rob_tag_t              tag_q  [isa_pkg::NUM_REGS];
    logic [isa_pkg::NUM_REGS-1:0]    busy_q;

    assign issue_en = ins_valid & ~ins_stall;
    assign issue_op = ins_op;
    assign issue_rd = ins_rd;

    // ROB is asked about whichever entry renames each source
    assign rob_rd_tag_a = tag_q[ins_rs1];
    assign rob_rd_tag_b = tag_q[ins_rs2];

    // priority: x0, not renamed, done in ROB, on the bus this cycle
    function automatic void resolve(
        input  isa_pkg::reg_idx_t  idx,
        input  logic               rob_ready,
        input  isa_pkg::data_t     rob_value,
        output isa_pkg::data_t     val,
        output core_pkg::rob_tag_t q,
        output logic               rdy
    );
        val = '0;
        q   = tag_q[idx];
        rdy = 1'b1;
        if (idx == '0) begin
            val = '0;
        end else if (!busy_q[idx]) begin
            val = rf_q[idx];
        end else if (rob_ready) begin
            val = rob_value;
        end else if (cdb_valid && cdb_tag == tag_q[idx]) begin
            val = cdb_value;
        end else begin
            rdy = 1'b0;
        end
    endfunction

    always_comb begin
        resolve(ins_rs1, rob_rd_ready_a, rob_rd_value_a, vj, qj, rj);
        if (ins_use_imm) begin
            vk = ins_imm;
            qk = '0;
            rk = 1'b1;
        end else begin
            resolve(ins_rs2, rob_rd_ready_b, rob_rd_value_b, vk, qk, rk);
        end
    end

    // commit writes first, a new rename on the same edge wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                rf_q[i]  <= '0;
                tag_q[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                rf_q[commit_rd] <= commit_data;
                // only the youngest writer may clear the busy bit
                if (busy_q[commit_rd] && tag_q[commit_rd] == commit_tag) begin
                    busy_q[commit_rd] <= 1'b0;
                end
            end
            if (issue_en && ins_rd != '0) begin
                busy_q[ins_rd] <= 1'b1;
                tag_q[ins_rd]  <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/reservation_stations.sv */
// ------------------------------------------------
// reservation stations
// operand wait, bus snoop and in-order-by-index dispatch
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reservation_stations #(
    parameter int NUM_RS = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_en,
    input  isa_pkg::alu_op_e    issue_op,
    input  core_pkg::rob_tag_t  alloc_tag,
    input  isa_pkg::data_t      vj,
    input  isa_pkg::data_t      vk,
    input  core_pkg::rob_tag_t  qj,
    input  core_pkg::rob_tag_t  qk,
    input  logic                rj,
    input  logic                rk,
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    output logic                rs_full,
    output logic                disp_valid,
    output isa_pkg::alu_op_e    disp_op,
    output core_pkg::rob_tag_t  disp_tag,
    output isa_pkg::data_t      disp_a,
    output isa_pkg::data_t      disp_b
);

    localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;

    logic [NUM_RS-1:0]    busy_q;
    logic [NUM_RS-1:0]    ra_q;
    logic [NUM_RS-1:0]    rb_q;
    isa_pkg::alu_op_e     op_q  [NUM_RS];
    core_pkg::rob_tag_t   tag_q [NUM_RS];
    isa_pkg::data_t       va_q  [NUM_RS];
    isa_pkg::data_t       vb_q  [NUM_RS];
    core_pkg::rob_tag_t   qa_q  [NUM_RS];
    core_pkg::rob_tag_t   qb_q  [NUM_RS];

    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     disp_idx;

    assign rs_full = &busy_q;

    // lowest free and lowest ready entry, scanning down so index 0 wins
    always_comb begin
        free_idx   = '0;
        disp_idx   = '0;
        disp_valid = 1'b0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (busy_q[i] && ra_q[i] && rb_q[i]) begin
                disp_idx   = IDX_W'(i);
                disp_valid = 1'b1;
            end
        end
    end

    assign disp_op  = op_q[disp_idx];
    assign disp_tag = tag_q[disp_idx];
    assign disp_a   = va_q[disp_idx];
    assign disp_b   = vb_q[disp_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            if (disp_valid) begin
                busy_q[disp_idx] <= 1'b0;
            end
            if (issue_en) begin
                busy_q[free_idx] <= 1'b1;
            end
        end
    end

    // operand slots, only meaningful while busy
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_RS; i++) begin
            if (busy_q[i] && cdb_valid) begin
                if (!ra_q[i] && qa_q[i] == cdb_tag) begin
                    va_q[i] <= cdb_value;
                    ra_q[i] <= 1'b1;
                end
                if (!rb_q[i] && qb_q[i] == cdb_tag) begin
                    vb_q[i] <= cdb_value;
                    rb_q[i] <= 1'b1;
                end
            end
        end
        if (issue_en) begin
            op_q[free_idx]  <= issue_op;
            tag_q[free_idx] <= alloc_tag;
            va_q[free_idx]  <= vj;
            vb_q[free_idx]  <= vk;
            qa_q[free_idx]  <= qj;
            qb_q[free_idx]  <= qk;
            ra_q[free_idx]  <= rj;
            rb_q[free_idx]  <= rk;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_pipe.sv */
// ------------------------------------------------
// ALU pipe
// pipelined integer ALU, sole driver of the CDB
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                disp_valid,
    input  isa_pkg::alu_op_e    disp_op,
    input  core_pkg::rob_tag_t  disp_tag,
    input  isa_pkg::data_t      disp_a,
    input  isa_pkg::data_t      disp_b,
    output logic                cdb_valid,
    output core_pkg::rob_tag_t  cdb_tag,
    output isa_pkg::data_t      cdb_value
);

    localparam int N = core_pkg::ALU_STAGES;

    isa_pkg::data_t      result;
    logic [N-1:0]        valid_q;
    core_pkg::rob_tag_t  tag_q   [N];
    isa_pkg::data_t      value_q [N];

    // first stage: compute
    always_comb begin
        case (disp_op)
            isa_pkg::OP_ADD: result = disp_a + disp_b;
            isa_pkg::OP_SUB: result = disp_a - disp_b;
            isa_pkg::OP_AND: result = disp_a & disp_b;
            isa_pkg::OP_OR:  result = disp_a | disp_b;
            isa_pkg::OP_XOR: result = disp_a ^ disp_b;
            isa_pkg::OP_SLT: result = ($signed(disp_a) < $signed(disp_b)) ? 32'd1 : 32'd0;
            isa_pkg::OP_SLL: result = disp_a << disp_b[4:0];
            isa_pkg::OP_SRL: result = disp_a >> disp_b[4:0];
            default:         result = '0;
        endcase
    end

    // valid bits travel with the data through every stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[N-2:0], disp_valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]   <= disp_tag;
        value_q[0] <= result;
        for (int i = 1; i < N; i++) begin
            tag_q[i]   <= tag_q[i-1];
            value_q[i] <= value_q[i-1];
        end
    end

    // last stage is the bus
    assign cdb_valid = valid_q[N-1];
    assign cdb_tag   = tag_q[N-1];
    assign cdb_value = value_q[N-1];

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
// ------------------------------------------------
// reorder buffer
// tag allocation, result capture and in-order retire
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_en,
    input  isa_pkg::reg_idx_t   issue_rd,
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    input  core_pkg::rob_tag_t  rob_rd_tag_a,
    input  core_pkg::rob_tag_t  rob_rd_tag_b,
    output core_pkg::rob_tag_t  alloc_tag,
    output logic                rob_full,
    output logic                rob_rd_ready_a,
    output logic                rob_rd_ready_b,
    output isa_pkg::data_t      rob_rd_value_a,
    output isa_pkg::data_t      rob_rd_value_b,
    output logic                commit_valid,
    output core_pkg::rob_tag_t  commit_tag,
    output isa_pkg::reg_idx_t   commit_rd,
    output isa_pkg::data_t      commit_data
);

    localparam int DEPTH = core_pkg::ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    core_pkg::rob_state_e  state_q [DEPTH];
    isa_pkg::reg_idx_t     rd_q    [DEPTH];
    isa_pkg::data_t        value_q [DEPTH];
    core_pkg::rob_tag_t    head_q;
    core_pkg::rob_tag_t    tail_q;
    logic [CNT_W-1:0]      count_q;

    function automatic core_pkg::rob_tag_t next_ptr(input core_pkg::rob_tag_t p);
        return (p == core_pkg::rob_tag_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_tag = tail_q;
    assign rob_full  = (count_q == CNT_W'(DEPTH));

    // head retires once its result is in
    assign commit_valid = (state_q[head_q] == core_pkg::ROB_DONE);
    assign commit_tag   = head_q;
    assign commit_rd    = rd_q[head_q];
    assign commit_data  = value_q[head_q];

    // operand lookups for the issue unit
    assign rob_rd_ready_a = (state_q[rob_rd_tag_a] == core_pkg::ROB_DONE);
    assign rob_rd_ready_b = (state_q[rob_rd_tag_b] == core_pkg::ROB_DONE);
    assign rob_rd_value_a = value_q[rob_rd_tag_a];
    assign rob_rd_value_b = value_q[rob_rd_tag_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= core_pkg::ROB_FREE;
            end
        end else begin
            if (commit_valid) begin
                state_q[head_q] <= core_pkg::ROB_FREE;
                head_q          <= next_ptr(head_q);
            end
            if (cdb_valid) begin
                state_q[cdb_tag] <= core_pkg::ROB_DONE;
            end
            if (issue_en) begin
                state_q[tail_q] <= core_pkg::ROB_WAIT;
                tail_q          <= next_ptr(tail_q);
            end
            case ({issue_en, commit_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;
        end
        if (issue_en) begin
            rd_q[tail_q] <= issue_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/tomasulo_core.sv */
// ------------------------------------------------
// tomasulo core
// issue, reservation stations, ALU and ROB
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
    parameter int NUM_RS = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ins_valid,
    input  isa_pkg::alu_op_e    ins_op,
    input  isa_pkg::reg_idx_t   ins_rd,
    input  isa_pkg::reg_idx_t   ins_rs1,
    input  isa_pkg::reg_idx_t   ins_rs2,
    input  logic                ins_use_imm,
    input  isa_pkg::data_t      ins_imm,
    output logic                ins_stall,
    output logic                commit_valid,
    output isa_pkg::reg_idx_t   commit_rd,
    output isa_pkg::data_t      commit_data
);

    // ------------------------------------------------
    // interconnect
    // ------------------------------------------------
    logic                issue_en;
    isa_pkg::alu_op_e    issue_op;
    isa_pkg::reg_idx_t   issue_rd;
    isa_pkg::data_t      vj, vk;
    core_pkg::rob_tag_t  qj, qk;
    logic                rj, rk;
    core_pkg::rob_tag_t  alloc_tag;
    logic                rob_full, rs_full;
    core_pkg::rob_tag_t  rob_rd_tag_a, rob_rd_tag_b;
    logic                rob_rd_ready_a, rob_rd_ready_b;
    isa_pkg::data_t      rob_rd_value_a, rob_rd_value_b;
    logic                disp_valid;
    isa_pkg::alu_op_e    disp_op;
    core_pkg::rob_tag_t  disp_tag;
    isa_pkg::data_t      disp_a, disp_b;
    logic                cdb_valid;
    core_pkg::rob_tag_t  cdb_tag;
    isa_pkg::data_t      cdb_value;
    core_pkg::rob_tag_t  commit_tag;

    // hold the stream while there is nowhere to put an instruction
    assign ins_stall = rob_full | rs_full;

    // ------------------------------------------------
    // units
    // ------------------------------------------------
    issue_unit u_issue (
        .clk, .arst_n,
        .ins_valid, .ins_op, .ins_rd, .ins_rs1, .ins_rs2, .ins_use_imm, .ins_imm,
        .ins_stall, .alloc_tag,
        .rob_rd_ready_a, .rob_rd_ready_b, .rob_rd_value_a, .rob_rd_value_b,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_tag, .commit_rd, .commit_data,
        .issue_en, .issue_op, .issue_rd,
        .vj, .vk, .qj, .qk, .rj, .rk,
        .rob_rd_tag_a, .rob_rd_tag_b
    );

    reservation_stations #(
        .NUM_RS(NUM_RS)
    ) u_rs (
        .clk, .arst_n,
        .issue_en, .issue_op, .alloc_tag,
        .vj, .vk, .qj, .qk, .rj, .rk,
        .cdb_valid, .cdb_tag, .cdb_value,
        .rs_full,
        .disp_valid, .disp_op, .disp_tag, .disp_a, .disp_b
    );

    alu_pipe u_alu (
        .clk, .arst_n,
        .disp_valid, .disp_op, .disp_tag, .disp_a, .disp_b,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer u_rob (
        .clk, .arst_n,
        .issue_en, .issue_rd,
        .cdb_valid, .cdb_tag, .cdb_value,
        .rob_rd_tag_a, .rob_rd_tag_b,
        .alloc_tag, .rob_full,
        .rob_rd_ready_a, .rob_rd_ready_b, .rob_rd_value_a, .rob_rd_value_b,
        .commit_valid, .commit_tag, .commit_rd, .commit_data
    );

endmodule

`default_nettype wire

/* dv/core_model.svh */
// ------------------------------------------------
// core reference model
// in-order execution and the expected commit queue
// ------------------------------------------------
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural registers as the program sees them
isa_pkg::data_t    model_rf   [isa_pkg::NUM_REGS];

// one entry per accepted instruction, oldest first
isa_pkg::reg_idx_t exp_rd_q   [$];
isa_pkg::data_t    exp_data_q [$];

function automatic isa_pkg::data_t model_alu(
    input isa_pkg::alu_op_e op,
    input isa_pkg::data_t   a,
    input isa_pkg::data_t   b
);
    int signed sa;
    int signed sb;
    sa = a;
    sb = b;
    case (op)
        isa_pkg::OP_ADD: return a + b;
        isa_pkg::OP_SUB: return a - b;
        isa_pkg::OP_AND: return a & b;
        isa_pkg::OP_OR:  return a | b;
        isa_pkg::OP_XOR: return a ^ b;
        isa_pkg::OP_SLT: return (sa < sb) ? 1 : 0;
        // shift amount is the low 5 bits only
        isa_pkg::OP_SLL: return a << b[4:0];
        isa_pkg::OP_SRL: return a >> b[4:0];
        default:         return '0;
    endcase
endfunction

function automatic void model_reset();
    for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        model_rf[i] = '0;
    end
    exp_rd_q.delete();
    exp_data_q.delete();
endfunction

// executes one instruction in program order
function automatic void model_issue(
    input isa_pkg::alu_op_e  op,
    input isa_pkg::reg_idx_t rd,
    input isa_pkg::reg_idx_t rs1,
    input isa_pkg::reg_idx_t rs2,
    input logic              use_imm,
    input isa_pkg::data_t    imm
);
    isa_pkg::data_t a;
    isa_pkg::data_t b;
    isa_pkg::data_t r;
    a = (rs1 == 0) ? '0 : model_rf[rs1];
    b = use_imm ? imm : ((rs2 == 0) ? '0 : model_rf[rs2]);
    r = model_alu(op, a, b);
    // x0 still commits its data but is never written
    if (rd != 0) begin
        model_rf[rd] = r;
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(r);
endfunction

`endif

/* dv/tb_tomasulo_core.sv */
// ------------------------------------------------
// tomasulo core testbench
// random instruction stream checked against a model
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_core;

    localparam int          NUM_WARMUP      = 8;
    localparam int          NUM_RANDOM      = 300;
    localparam int          NUM_BURST       = 60;
    localparam int          TOTAL           = NUM_WARMUP + NUM_RANDOM + NUM_BURST;
    localparam int          WATCHDOG_CYCLES = TOTAL * core_pkg::ROB_DEPTH * 10;
    localparam int unsigned SEED            = 32'h38cd26fa;

    logic               clk;
    logic               arst_n;
    logic               ins_valid;
    isa_pkg::alu_op_e   ins_op;
    isa_pkg::reg_idx_t  ins_rd;
    isa_pkg::reg_idx_t  ins_rs1;
    isa_pkg::reg_idx_t  ins_rs2;
    logic               ins_use_imm;
    isa_pkg::data_t     ins_imm;
    logic               ins_stall;
    logic               commit_valid;
    isa_pkg::reg_idx_t  commit_rd;
    isa_pkg::data_t     commit_data;

    // monitor state is written on the rising edge and read on the falling one
    logic               accepted;
    int                 stall_cycles;
    isa_pkg::reg_idx_t  exp_rd;
    isa_pkg::data_t     exp_data;

    `include "core_model.svh"

    tomasulo_core #(
        .NUM_RS(4)
    ) UUT (
        .clk, .arst_n,
        .ins_valid, .ins_op, .ins_rd, .ins_rs1, .ins_rs2, .ins_use_imm, .ins_imm,
        .ins_stall, .commit_valid, .commit_rd, .commit_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_data(input string name, input isa_pkg::data_t got,
                              input isa_pkg::data_t exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input isa_pkg::reg_idx_t got,
                             input isa_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------
    // monitor checks commits before the acceptance
    // ------------------------------------------------
    always @(posedge clk) begin
        accepted = 1'b0;
        if (arst_n) begin
            if (commit_valid) begin
                if (exp_rd_q.size() == 0) begin
                    report_error("commit seen with no instruction outstanding");
                end
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_reg("commit_rd", commit_rd, exp_rd);
                check_data("commit_data", commit_data, exp_data);
            end
            if (ins_stall) begin
                stall_cycles++;
            end
            if (ins_valid && !ins_stall) begin
                accepted = 1'b1;
                model_issue(ins_op, ins_rd, ins_rs1, ins_rs2, ins_use_imm, ins_imm);
                if (exp_rd_q.size() > core_pkg::ROB_DEPTH) begin
                    report_error("more instructions in flight than ROB entries");
                end
            end
        end
    end

    // ------------------------------------------------
    // stimulus is always applied on the falling edge
    // ------------------------------------------------
    // holds the instruction until the core takes it
    task automatic drive_one(input isa_pkg::alu_op_e op, input isa_pkg::reg_idx_t rd,
                             input isa_pkg::reg_idx_t rs1, input isa_pkg::reg_idx_t rs2,
                             input logic use_imm, input isa_pkg::data_t imm);
        ins_valid   = 1'b1;
        ins_op      = op;
        ins_rd      = rd;
        ins_rs1     = rs1;
        ins_rs2     = rs2;
        ins_use_imm = use_imm;
        ins_imm     = imm;
        do begin
            @(negedge clk);
        end while (!accepted);
    endtask

    // small pool so that dependency chains form
    // the burst uses only x1 and x2
    function automatic isa_pkg::reg_idx_t pick_reg(input bit burst);
        if (burst) begin
            return isa_pkg::reg_idx_t'(1 + $urandom_range(1));
        end
        if ($urandom_range(7) == 0) begin
            return isa_pkg::reg_idx_t'($urandom_range(31));
        end
        return isa_pkg::reg_idx_t'($urandom_range(3));
    endfunction

    task automatic drive_stream(input int count, input bit burst);
        isa_pkg::alu_op_e  op;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        logic              use_imm;
        for (int i = 0; i < count; i++) begin
            // about 70% density outside the burst
            while (!burst && $urandom_range(99) >= 70) begin
                ins_valid = 1'b0;
                @(negedge clk);
            end
            op      = isa_pkg::alu_op_e'($urandom_range(7));
            rd      = pick_reg(burst);
            rs1     = pick_reg(burst);
            rs2     = pick_reg(burst);
            use_imm = burst ? ($urandom_range(7) == 0) : $urandom_range(1);
            drive_one(op, rd, rs1, rs2, use_imm, $urandom);
        end
        ins_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n       = 1'b0;
        ins_valid    = 1'b0;
        ins_op       = isa_pkg::OP_ADD;
        ins_rd       = '0;
        ins_rs1      = '0;
        ins_rs2      = '0;
        ins_use_imm  = 1'b0;
        ins_imm      = '0;
        stall_cycles = 0;
        model_reset();

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("ins_stall", ins_stall, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);

        // each opcode once with an immediate and chained through x1..x8
        for (int k = 0; k < NUM_WARMUP; k++) begin
            drive_one(isa_pkg::alu_op_e'(k), isa_pkg::reg_idx_t'(k + 1),
                      isa_pkg::reg_idx_t'(k), '0, 1'b1, $urandom);
        end
        ins_valid = 1'b0;

        drive_stream(NUM_RANDOM, 1'b0);
        drive_stream(NUM_BURST, 1'b1);

        // drain and make sure nothing extra commits
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);

        if (stall_cycles > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("ERROR: ins_stall never went high during the run");
            abort_run();
        end
    end

    // bound on the whole run
    initial begin
        @(posedge arst_n);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired, commits stalled with %0d outstanding",
                 exp_rd_q.size());
        abort_run();
    end

endmodule

`default_nettype wire

/* tomasulo_core.f */
+incdir+dv
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/issue_unit.sv
rtl/reservation_stations.sv
rtl/alu_pipe.sv
rtl/reorder_buffer.sv
rtl/tomasulo_core.sv
dv/tb_tomasulo_core.sv

/* Bender.yml */
package:
  name: tomasulo_core

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/core_pkg.sv
      - rtl/issue_unit.sv
      - rtl/reservation_stations.sv
      - rtl/alu_pipe.sv
      - rtl/reorder_buffer.sv
      - rtl/tomasulo_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_tomasulo_core.sv
